// File: Makefile
# Verilator build and run for the omega read unit

TOP       ?= tb_omega_read
SEED      ?= 3351190176
LOG       ?= sim.log
BUILD     ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
FILELIST  ?= src.f

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Gseed_init=$(SEED) \
		--Mdir $(BUILD) -f $(FILELIST)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "^Simulation PASSED$$" $(LOG) || (echo "run failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// File: rtl/omega_fabric.sv
`timescale 1ns/1ps

module omega_fabric
    import omega_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst,
    input  route_pkt_t  [NUM_PORTS-1:0]  issue_pkts,
    output return_pkt_t [NUM_PORTS-1:0]  ret_pkts
);

    route_pkt_t  [NUM_PORTS-1:0] route_link [NUM_STAGES+1];
    return_pkt_t [NUM_PORTS-1:0] ret_link   [NUM_STAGES+1];
    sw_decision_t                dec        [NUM_STAGES];

    assign route_link[0] = issue_pkts;

    // Most significant address bit is routed first
    for (genvar s = 0; s < NUM_STAGES; s++) begin : g_route
        route_stage #(
            .stage_bit(ADDR_W - 1 - s)
        ) u_route_stage (
            .clk      (clk),
            .rst      (rst),
            .in_pkts  (route_link[s]),
            .out_pkts (route_link[s+1]),
            .decision (dec[s])
        );
    end

    // Store lookup at each surviving output position
    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            ret_link[0][p] = '0;
            if (route_link[NUM_STAGES][p].valid) begin
                ret_link[0][p].valid = 1'b1;
                ret_link[0][p].data  = store_word(route_link[NUM_STAGES][p].addr);
            end
        end
    end

    // Return path walks the route stages backwards
    for (genvar s = 0; s < NUM_STAGES; s++) begin : g_return
        return_stage u_return_stage (
            .clk      (clk),
            .rst      (rst),
            .in_pkts  (ret_link[s]),
            .decision (dec[NUM_STAGES-1-s]),
            .out_pkts (ret_link[s+1])
        );
    end

    assign ret_pkts = ret_link[NUM_STAGES];

endmodule

// File: rtl/omega_pkg.sv
package omega_pkg;

    // Network geometry
    localparam int NUM_PORTS      = 8;
    localparam int ADDR_W         = $clog2(NUM_PORTS);
    localparam int NUM_STAGES     = ADDR_W;
    localparam int DATA_W         = 16;
    localparam int NUM_SW         = NUM_PORTS / 2;
    // Route stages plus return stages, one register each
    localparam int FABRIC_LATENCY = 2 * NUM_STAGES;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] word_t;

    typedef addr_t [NUM_PORTS-1:0] addr_vec_t;
    typedef word_t [NUM_PORTS-1:0] word_vec_t;

    // Forward packet toward the store
    typedef struct packed {
        logic  valid;
        addr_t addr;
    } route_pkt_t;

    // Backward packet, data is zero when not valid
    typedef struct packed {
        logic  valid;
        word_t data;
    } return_pkt_t;

    // Per-stage switch settings, one bit per switch
    typedef struct packed {
        logic [NUM_SW-1:0] swap;
        logic [NUM_SW-1:0] merge;
    } sw_decision_t;

    typedef enum logic [2:0] {
        IDLE,
        ISSUE,
        WAIT,
        CAPTURE,
        DONE
    } seq_state_t;

    // Fixed store contents
    function automatic word_t store_word(addr_t a);
        word_t all_ones;
        all_ones = '1;
        return all_ones - word_t'(a);
    endfunction

endpackage

// File: rtl/omega_read_top.sv
`timescale 1ns/1ps

module omega_read_top
    import omega_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      req,
    input  addr_vec_t req_addrs,
    output logic      ack,
    output logic      resp_req,
    input  logic      resp_ack,
    output word_vec_t resp_data
);

    logic                        start;
    logic                        done;
    logic                        busy_clear;
    addr_vec_t                   addrs;
    word_vec_t                   words;
    route_pkt_t  [NUM_PORTS-1:0] issue_pkts;
    return_pkt_t [NUM_PORTS-1:0] ret_pkts;

    request_port u_request_port (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .req_addrs  (req_addrs),
        .busy_clear (busy_clear),
        .ack        (ack),
        .start      (start),
        .addrs      (addrs)
    );

    retry_sequencer u_retry_sequencer (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .addrs      (addrs),
        .ret_pkts   (ret_pkts),
        .issue_pkts (issue_pkts),
        .done       (done),
        .words      (words)
    );

    omega_fabric u_omega_fabric (
        .clk        (clk),
        .rst        (rst),
        .issue_pkts (issue_pkts),
        .ret_pkts   (ret_pkts)
    );

    response_port u_response_port (
        .clk        (clk),
        .rst        (rst),
        .done       (done),
        .words      (words),
        .resp_ack   (resp_ack),
        .resp_req   (resp_req),
        .resp_data  (resp_data),
        .busy_clear (busy_clear)
    );

endmodule

// File: rtl/request_port.sv
`timescale 1ns/1ps

module request_port
    import omega_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      req,
    input  addr_vec_t req_addrs,
    input  logic      busy_clear,
    output logic      ack,
    output logic      start,
    output addr_vec_t addrs
);

    // Set from acceptance until the response handshake finishes
    logic busy;
    logic accept;

    assign accept = req && !ack && !busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            ack   <= 1'b0;
            start <= 1'b0;
            busy  <= 1'b0;
        end else begin
            start <= accept;
            if (accept) begin
                ack  <= 1'b1;
                busy <= 1'b1;
            end else begin
                if (!req && ack) begin
                    ack <= 1'b0;
                end
                if (busy_clear) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // Addresses sampled once per request
    always_ff @(posedge clk) begin
        if (accept) begin
            addrs <= req_addrs;
        end
    end

    a_no_ack_while_busy: assert property (@(posedge clk) disable iff (rst)
        $rose(ack) |-> !$past(busy));

endmodule

// File: rtl/response_port.sv
`timescale 1ns/1ps

module response_port
    import omega_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      done,
    input  word_vec_t words,
    input  logic      resp_ack,
    output logic      resp_req,
    output word_vec_t resp_data,
    output logic      busy_clear
);

    // Waiting for the host to drop resp_ack
    logic ack_seen;

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_req   <= 1'b0;
            ack_seen   <= 1'b0;
            busy_clear <= 1'b0;
        end else begin
            busy_clear <= 1'b0;
            if (done) begin
                resp_req <= 1'b1;
            end else if (resp_req && resp_ack) begin
                resp_req <= 1'b0;
                ack_seen <= 1'b1;
            end else if (ack_seen && !resp_ack) begin
                ack_seen   <= 1'b0;
                busy_clear <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (done) begin
            resp_data <= words;
        end
    end

    a_data_stable: assert property (@(posedge clk) disable iff (rst)
        resp_req |=> !resp_req || $stable(resp_data));

    // Intake must stay blocked until this handshake is over
    a_no_overlap: assert property (@(posedge clk) disable iff (rst)
        done |-> !resp_req && !ack_seen);

endmodule

// File: rtl/retry_sequencer.sv
`timescale 1ns/1ps

module retry_sequencer
    import omega_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          start,
    input  addr_vec_t                     addrs,
    input  return_pkt_t [NUM_PORTS-1:0]   ret_pkts,
    output route_pkt_t  [NUM_PORTS-1:0]   issue_pkts,
    output logic                          done,
    output word_vec_t                     words
);

    localparam int CNT_W = $clog2(FABRIC_LATENCY);

    seq_state_t           state;
    seq_state_t           state_nxt;
    logic [CNT_W-1:0]     wait_cnt;
    logic [NUM_PORTS-1:0] pending;
    logic [NUM_PORTS-1:0] ret_valid;
    logic [NUM_PORTS-1:0] pending_left;
    addr_vec_t            stored_addrs;

    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            ret_valid[i] = ret_pkts[i].valid;
        end
    end

    // Ports still open once this round's returns are taken
    assign pending_left = pending & ~ret_valid;

    // Only pending ports go out, and only in the issue cycle
    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            issue_pkts[i] = '0;
            if (state == ISSUE && pending[i]) begin
                issue_pkts[i].valid = 1'b1;
                issue_pkts[i].addr  = stored_addrs[i];
            end
        end
    end

    assign done = (state == DONE);

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (start) state_nxt = ISSUE;
            ISSUE:   state_nxt = WAIT;
            // Lands on CAPTURE exactly FABRIC_LATENCY cycles after ISSUE
            WAIT:    if (wait_cnt == CNT_W'(FABRIC_LATENCY - 2)) state_nxt = CAPTURE;
            CAPTURE: state_nxt = (pending_left == '0) ? DONE : ISSUE;
            DONE:    state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            wait_cnt <= '0;
            pending  <= '0;
        end else begin
            state <= state_nxt;
            if (state == ISSUE) begin
                wait_cnt <= '0;
            end else if (state == WAIT) begin
                wait_cnt <= wait_cnt + 1'b1;
            end
            if (state == IDLE && start) begin
                pending <= '1;
            end else if (state == CAPTURE) begin
                pending <= pending_left;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            stored_addrs <= addrs;
        end
        if (state == CAPTURE) begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                if (ret_valid[i] && pending[i]) begin
                    words[i] <= ret_pkts[i].data;
                end
            end
        end
    end

    // Returns only show up at capture time and only for issued ports
    a_ret_for_issued: assert property (@(posedge clk) disable iff (rst)
        (|ret_valid) |-> (state == CAPTURE) && ((ret_valid & ~pending) == '0));

    a_pending_no_grow: assert property (@(posedge clk) disable iff (rst)
        !start |=> ((pending & ~$past(pending)) == '0));

endmodule

// File: rtl/return_stage.sv
`timescale 1ns/1ps

module return_stage
    import omega_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst,
    input  return_pkt_t [NUM_PORTS-1:0]  in_pkts,
    input  sw_decision_t                 decision,
    output return_pkt_t [NUM_PORTS-1:0]  out_pkts
);

    return_pkt_t [NUM_PORTS-1:0] sw_pkts;
    return_pkt_t [NUM_PORTS-1:0] nxt_pkts;

    for (genvar i = 0; i < NUM_SW; i++) begin : g_sw
        return_pkt_t up;
        return_pkt_t dn;
        return_pkt_t both;

        assign up = in_pkts[2*i];
        assign dn = in_pkts[2*i+1];
        // On a merge the other input is all zero, so OR picks the survivor
        assign both = up | dn;

        assign sw_pkts[2*i]   = decision.merge[i] ? both : (decision.swap[i] ? dn : up);
        assign sw_pkts[2*i+1] = decision.merge[i] ? both : (decision.swap[i] ? up : dn);
    end

    // Inverse shuffle, rotate position right by one
    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_unshuffle
        localparam int dst = (i / 2) + ((i % 2) * (NUM_PORTS / 2));
        assign nxt_pkts[dst] = sw_pkts[i];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_pkts <= '0;
        end else begin
            out_pkts <= nxt_pkts;
        end
    end

endmodule

// File: rtl/route_stage.sv
`timescale 1ns/1ps

module route_stage
    import omega_pkg::*;
#(
    parameter int stage_bit = 0
) (
    input  logic                        clk,
    input  logic                        rst,
    input  route_pkt_t [NUM_PORTS-1:0]  in_pkts,
    output route_pkt_t [NUM_PORTS-1:0]  out_pkts,
    output sw_decision_t                decision
);

    route_pkt_t [NUM_PORTS-1:0] sh_pkts;
    route_pkt_t [NUM_PORTS-1:0] nxt_pkts;
    logic [NUM_PORTS-1:0]       in_valid;
    logic [NUM_SW-1:0]          sw_swap;
    logic [NUM_SW-1:0]          sw_merge;
    logic [NUM_SW-1:0]          both_valid;
    logic                       load;

    // Perfect shuffle, rotate position left by one
    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_shuffle
        localparam int dst = ((i << 1) % NUM_PORTS) + (i / (NUM_PORTS / 2));
        assign sh_pkts[dst] = in_pkts[i];
        assign in_valid[i]  = in_pkts[i].valid;
    end

    for (genvar i = 0; i < NUM_SW; i++) begin : g_sw
        route_pkt_t up;
        route_pkt_t dn;
        route_pkt_t x0;
        route_pkt_t x1;

        assign up = sh_pkts[2*i];
        assign dn = sh_pkts[2*i+1];

        // Upper input has priority when setting the switch
        assign sw_swap[i]    = up.valid ? up.addr[stage_bit] : (dn.valid && !dn.addr[stage_bit]);
        assign both_valid[i] = up.valid && dn.valid;
        assign sw_merge[i]   = both_valid[i] && (up.addr == dn.addr);

        assign x0 = sw_swap[i] ? dn : up;
        assign x1 = sw_swap[i] ? up : dn;

        // Misrouted packets are killed and retried later
        assign nxt_pkts[2*i]   = (x0.valid && !x0.addr[stage_bit]) ? x0 : '0;
        assign nxt_pkts[2*i+1] = (x1.valid && x1.addr[stage_bit]) ? x1 : '0;
    end

    assign load = |in_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_pkts <= '0;
            decision <= '0;
        end else begin
            out_pkts <= nxt_pkts;
            // Held until the next wave so the return path sees this wave's settings
            if (load) begin
                decision.swap  <= sw_swap;
                decision.merge <= sw_merge;
            end
        end
    end

    // Merged pair had two valid inputs and leaves a single survivor
    for (genvar i = 0; i < NUM_SW; i++) begin : g_merge_check
        a_merge_both_valid: assert property (@(posedge clk) disable iff (rst)
            load |=> !decision.merge[i] ||
                ($past(both_valid[i]) && (out_pkts[2*i].valid != out_pkts[2*i+1].valid)));
    end

endmodule

// File: src.f
rtl/omega_pkg.sv
rtl/request_port.sv
rtl/retry_sequencer.sv
rtl/route_stage.sv
rtl/return_stage.sv
rtl/omega_fabric.sv
rtl/response_port.sv
rtl/omega_read_top.sv
testbench/tb_omega_read.sv

// File: testbench/tb_omega_read.sv
`timescale 1ns/1ps

module tb_omega_read
    import omega_pkg::*;
#(
    parameter logic [31:0] seed_init = 32'hc7bf_1aa0
);

    localparam int ACK_TIMEOUT  = 200;
    localparam int RESP_TIMEOUT = 400;

    logic      clk;
    logic      rst;
    logic      req;
    addr_vec_t req_addrs;
    logic      ack;
    logic      resp_req;
    logic      resp_ack;
    word_vec_t resp_data;

    // Addresses of the request whose response is due next
    addr_vec_t acked_addrs;
    logic      outstanding;
    logic      timed_out;
    int        error_count;
    int        errors_at_start;
    int        tests_run;
    int        tests_failed;
    int        seed;

    omega_read_top u_omega_read_top (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .req_addrs (req_addrs),
        .ack       (ack),
        .resp_req  (resp_req),
        .resp_ack  (resp_ack),
        .resp_data (resp_data)
    );

    always #5 clk = ~clk;

    // Word i of the store is all-ones minus i
    function automatic word_t expected_word(addr_t a);
        return {DATA_W{1'b1}} - word_t'(a);
    endfunction

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_lane_check
        a_lane_word: assert property (@(posedge clk) disable iff (rst)
            $rose(resp_req) |-> resp_data[i] == expected_word(acked_addrs[i]))
        else begin
            $display("error at %0t: resp_data[%0d] expected %h got %h", $time, i,
                     expected_word(acked_addrs[i]), resp_data[i]);
            error_count++;
        end
    end

    a_data_held: assert property (@(posedge clk) disable iff (rst)
        resp_req && $past(resp_req) |-> $stable(resp_data))
    else begin
        $display("error at %0t: resp_data changed while resp_req was high", $time);
        error_count++;
    end

    // A new request may only be taken once the previous response is finished
    a_no_early_ack: assert property (@(posedge clk) disable iff (rst)
        $rose(ack) |-> !$past(outstanding))
    else begin
        $display("error at %0t: ack rose while a response was still open", $time);
        error_count++;
    end

    a_no_stray_resp: assert property (@(posedge clk) disable iff (rst)
        $rose(resp_req) |-> outstanding)
    else begin
        $display("error at %0t: resp_req rose with no request accepted", $time);
        error_count++;
    end

    task automatic send_request(input addr_vec_t addrs_in);
        int n;
        if (timed_out) return;
        req_addrs = addrs_in;
        req = 1'b1;
        n = 0;
        while (!ack && !timed_out) begin
            @(posedge clk);
            #1;
            n++;
            if (n >= ACK_TIMEOUT) begin
                $display("timeout at %0t: ack did not rise after req", $time);
                timed_out = 1'b1;
            end
        end
        if (timed_out) return;
        acked_addrs = addrs_in;
        outstanding = 1'b1;
        req = 1'b0;
        n = 0;
        while (ack && !timed_out) begin
            @(posedge clk);
            #1;
            n++;
            if (n >= ACK_TIMEOUT) begin
                $display("timeout at %0t: ack did not fall after req dropped", $time);
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic receive_response(input int hold_cycles);
        int n;
        if (timed_out) return;
        n = 0;
        while (!resp_req && !timed_out) begin
            @(posedge clk);
            #1;
            n++;
            if (n >= RESP_TIMEOUT) begin
                $display("timeout at %0t: resp_req never rose", $time);
                timed_out = 1'b1;
            end
        end
        if (timed_out) return;
        // Slow host keeps the response waiting
        for (int k = 0; k < hold_cycles; k++) begin
            @(posedge clk);
            #1;
        end
        resp_ack = 1'b1;
        n = 0;
        while (resp_req && !timed_out) begin
            @(posedge clk);
            #1;
            n++;
            if (n >= ACK_TIMEOUT) begin
                $display("timeout at %0t: resp_req did not fall after resp_ack", $time);
                timed_out = 1'b1;
            end
        end
        resp_ack = 1'b0;
        outstanding = 1'b0;
    endtask

    task automatic random_addrs(output addr_vec_t a);
        logic [31:0] r;
        for (int i = 0; i < NUM_PORTS; i++) begin
            r = $random(seed);
            a[i] = r[ADDR_W-1:0];
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (timed_out || error_count != errors_at_start) begin
            tests_failed++;
            $display("test %0d %s: failed", tests_run, name);
        end else begin
            $display("test %0d %s: ok", tests_run, name);
        end
        errors_at_start = error_count;
    endtask

    initial begin
        addr_vec_t a;
        addr_vec_t b;
        clk             = 1'b0;
        rst             = 1'b1;
        req             = 1'b0;
        req_addrs       = '0;
        resp_ack        = 1'b0;
        acked_addrs     = '0;
        outstanding     = 1'b0;
        timed_out       = 1'b0;
        error_count     = 0;
        errors_at_start = 0;
        tests_run       = 0;
        tests_failed    = 0;
        seed            = seed_init;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        check_ack_idle: assert (!ack) else begin
            $display("error at %0t: ack expected 0 got %b", $time, ack);
            error_count++;
        end
        check_resp_idle: assert (!resp_req) else begin
            $display("error at %0t: resp_req expected 0 got %b", $time, resp_req);
            error_count++;
        end
        // Quiet period, any response here is caught as stray
        repeat (20) @(posedge clk);
        #1;
        end_test("reset state");

        for (int i = 0; i < NUM_PORTS; i++) a[i] = addr_t'(i);
        send_request(a);
        receive_response(0);
        end_test("distinct addresses");

        for (int i = 0; i < NUM_PORTS; i++) a[i] = addr_t'(5);
        send_request(a);
        receive_response(0);
        end_test("one shared address");

        // Ports i and i+4 meet in one first-stage switch with different addresses
        for (int i = 0; i < NUM_PORTS; i++) a[i] = addr_t'(i / 2);
        send_request(a);
        receive_response(0);
        end_test("conflicting addresses");

        for (int r = 0; r < 20; r++) begin
            random_addrs(a);
            send_request(a);
            receive_response(0);
        end
        end_test("random addresses");

        for (int i = 0; i < NUM_PORTS; i++) a[i] = addr_t'(NUM_PORTS - 1 - i);
        for (int i = 0; i < NUM_PORTS; i++) b[i] = (i % 2 == 1) ? addr_t'(6) : addr_t'(2);
        send_request(a);
        fork
            receive_response(20);
            begin
                repeat (3) @(posedge clk);
                #1;
                send_request(b);
            end
        join
        receive_response(0);
        end_test("back-pressure");

        $display("tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed,
                 error_count);
        if (tests_failed == 0 && error_count == 0 && !timed_out) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
